//--- daq_frame.f
src/daq_pkg.sv
src/trig_if.sv
src/acq_timer.sv
src/trigger_fsm.sv
src/add_header_footer.sv
src/frame_fifo.sv
src/daq_channel_top.sv
bench/tb_daq_channel.sv

//--- bench/tb_daq_channel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_daq_channel;

  localparam int CHANNEL_ID         = 5;
  localparam int POST_TRIGGER_WORDS = 3;
  localparam int FIFO_DEPTH         = 16;
  localparam int DRIVEN_WORDS       = 168;  // words sent by all six tests together
  localparam int CYCLE_LIMIT        = 40 * DRIVEN_WORDS + 200;
  localparam int DRAIN_LIMIT        = 400;
  localparam int TS_LSB             = 8;    // time stamp sits above pad and id nibbles

  logic                               CLK;
  logic                               RESETN;
  logic                               s_valid;
  logic [daq_pkg::DATA_WIDTH-1:0]     s_data;
  wire                                s_ready;
  logic [daq_pkg::ADC_WIDTH-1:0]      threshold;
  logic [daq_pkg::ADC_WIDTH-1:0]      baseline;
  wire                                m_valid;
  wire  [daq_pkg::DATA_WIDTH-1:0]     m_data;
  logic                               m_ready;

  logic [31:0] lfsr_state;
  int          mismatch_count;
  int          failure_count;
  int          cycle_count;
  int          rx_words;
  logic        random_ready;
  logic        stall_output;
  string       test_name;

  // reference model of the frame rule, stepped once per accepted beat
  longint                         model_index;
  longint                         model_last_hit;
  logic                           model_has_hit;
  logic                           model_prev;   // triggered flag of the last beat
  logic                           model_prev2;
  logic [daq_pkg::DATA_WIDTH-1:0] model_word;
  logic [daq_pkg::ADC_WIDTH-1:0]  win_base;
  logic [daq_pkg::ADC_WIDTH-1:0]  win_thr;

  logic [daq_pkg::DATA_WIDTH-1:0]       exp_words[$];
  logic                                 exp_is_header[$];
  logic [daq_pkg::TIME_STAMP_WIDTH-1:0] exp_ts[$];

  daq_channel_top #(
    .CHANNEL_ID(CHANNEL_ID),
    .POST_TRIGGER_WORDS(POST_TRIGGER_WORDS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) DUT (
    .CLK(CLK), .RESETN(RESETN), .s_valid(s_valid), .s_data(s_data), .s_ready(s_ready),
    .threshold(threshold), .baseline(baseline),
    .m_valid(m_valid), .m_data(m_data), .m_ready(m_ready)
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      failure_count = failure_count + 1;
      finish_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // random words
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return r;
  endfunction

  function automatic logic [daq_pkg::DATA_WIDTH-1:0] quiet_word();
    logic [daq_pkg::DATA_WIDTH-1:0] w;
    for (int i = 0; i < daq_pkg::SAMPLES_PER_WORD; i++) begin
      // junk in the top nibble must not count
      w[i*daq_pkg::SAMPLE_WIDTH +: daq_pkg::SAMPLE_WIDTH] =
        {4'(random_bits(4)), 5'b0, 7'(random_bits(7))};
    end
    return w;
  endfunction

  function automatic logic [daq_pkg::DATA_WIDTH-1:0] hit_word();
    logic [daq_pkg::DATA_WIDTH-1:0] w;
    int                             slot;
    logic [3:0]                     junk;
    logic [daq_pkg::ADC_WIDTH-1:0]  level;
    w     = quiet_word();
    slot  = int'(random_bits(3));
    junk  = 4'(random_bits(4));
    level = baseline + threshold + 12'd1 + 12'(random_bits(8));
    w[slot*daq_pkg::SAMPLE_WIDTH +: daq_pkg::SAMPLE_WIDTH] = {junk, level};
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic has_hit(input logic [daq_pkg::DATA_WIDTH-1:0] w);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < daq_pkg::SAMPLES_PER_WORD; i++) begin
      if (int'(w[i*daq_pkg::SAMPLE_WIDTH +: daq_pkg::ADC_WIDTH]) >
          int'(baseline) + int'(threshold)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic logic [daq_pkg::DATA_WIDTH-1:0] header_word(
    input logic [daq_pkg::TIME_STAMP_WIDTH-1:0] ts
  );
    return {{64{1'b1}}, 4'hF, 4'(CHANNEL_ID), 4'hF, ts, 4'h0, daq_pkg::HEADER_ID};
  endfunction

  function automatic logic [daq_pkg::DATA_WIDTH-1:0] footer_word(
    input logic [daq_pkg::ADC_WIDTH-1:0] b,
    input logic [daq_pkg::ADC_WIDTH-1:0] t
  );
    return {{64{1'b1}}, 4'hF, b, 4'hF, t, 28'h0, daq_pkg::FOOTER_ID};
  endfunction

  task automatic expect_word(input logic [daq_pkg::DATA_WIDTH-1:0] w, input logic hdr,
                             input logic [daq_pkg::TIME_STAMP_WIDTH-1:0] ts);
    exp_words.push_back(w);
    exp_is_header.push_back(hdr);
    exp_ts.push_back(ts);
  endtask

  task automatic model_reset();
    model_index    = 0;
    model_last_hit = 0;
    model_has_hit  = 1'b0;
    model_prev     = 1'b0;
    model_prev2    = 1'b0;
    model_word     = '0;
    exp_words.delete();
    exp_is_header.delete();
    exp_ts.delete();
  endtask

  // the word of the previous beat is settled once this beat's flag is known
  task automatic model_accept(input logic [daq_pkg::DATA_WIDTH-1:0] w);
    logic hit;
    logic trig;
    hit  = has_hit(w);
    trig = hit || (model_prev && model_has_hit &&
                   (model_index - model_last_hit <= POST_TRIGGER_WORDS));
    if (model_prev2 && !model_prev) begin
      expect_word(footer_word(win_base, win_thr), 1'b0, '0);  // wins over a new header
    end else if (!model_prev && trig) begin
      expect_word(header_word(44'(model_index)), 1'b1, 44'(model_index));
    end else if (model_prev) begin
      expect_word(model_word, 1'b0, '0);
    end
    if (hit && !model_prev) begin
      win_base = baseline;
      win_thr  = threshold;
    end
    if (hit) begin
      model_last_hit = model_index;
      model_has_hit  = 1'b1;
    end
    model_prev2 = model_prev;
    model_prev  = trig;
    model_word  = w;
    model_index = model_index + 1;
  endtask

  task automatic compare_word(input string what, input logic [daq_pkg::DATA_WIDTH-1:0] expected,
                              input logic [daq_pkg::DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %h actual %h", test_name, what, expected, actual);
      mismatch_count = mismatch_count + 1;
    end
  endtask

  task automatic compare_time_stamp(input string what,
                                    input logic [daq_pkg::TIME_STAMP_WIDTH-1:0] expected,
                                    input logic [daq_pkg::TIME_STAMP_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %0d actual %0d", test_name, what, expected, actual);
      mismatch_count = mismatch_count + 1;
    end
  endtask

  task automatic compare_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s: expected %b actual %b", test_name, what, expected, actual);
      mismatch_count = mismatch_count + 1;
    end
  endtask

  task automatic check_output();
    logic [daq_pkg::DATA_WIDTH-1:0]       w;
    logic                                 hdr;
    logic [daq_pkg::TIME_STAMP_WIDTH-1:0] ts;
    rx_words = rx_words + 1;
    if (exp_words.size() == 0) begin
      $display("%s: the DUT put out word %h that belongs to no frame", test_name, m_data);
      failure_count = failure_count + 1;
    end else begin
      w   = exp_words.pop_front();
      hdr = exp_is_header.pop_front();
      ts  = exp_ts.pop_front();
      compare_word("m_data", w, m_data);
      if (hdr) begin
        compare_time_stamp("header time stamp", ts,
                           m_data[TS_LSB +: daq_pkg::TIME_STAMP_WIDTH]);
      end
    end
  endtask

  task automatic check_word_count(input int expected);
    if (rx_words != expected) begin
      $display("%s: %0d frame words came out where %0d belong", test_name, rx_words, expected);
      failure_count = failure_count + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // valid and both readies hold from here to the next rising edge
  task automatic tick();
    @(negedge CLK);
    if (stall_output) begin
      m_ready = 1'b0;  // output side blocked so the FIFO fills up
    end else begin
      m_ready = random_ready ? 1'(random_bits(1)) : 1'b1;
    end
    if (m_valid && m_ready) begin
      check_output();
    end
  endtask

  task automatic send_word(input logic [daq_pkg::DATA_WIDTH-1:0] w, input logic gapped);
    int gaps;
    gaps = gapped ? int'(random_bits(2)) : 0;
    repeat (gaps) begin
      tick();
      s_valid = 1'b0;
    end
    tick();
    s_valid = 1'b1;
    s_data  = w;
    while (!s_ready) begin
      tick();  // word stays put until the DUT takes it
    end
    model_accept(w);
  endtask

  task automatic send_quiet(input int n, input logic gapped);
    repeat (n) begin
      send_word(quiet_word(), gapped);
    end
  endtask

  // hits on every beat keep the window open until the DUT stops taking words
  task automatic send_until_full();
    logic [daq_pkg::DATA_WIDTH-1:0] w;
    w = hit_word();
    tick();
    s_valid = 1'b1;
    s_data  = w;
    while (s_ready) begin
      model_accept(w);
      w = hit_word();
      tick();
      s_data = w;
    end
  endtask

  task automatic drain();
    int waited;
    tick();
    s_valid = 1'b0;
    waited  = 0;
    while (exp_words.size() != 0 && waited < DRAIN_LIMIT) begin
      tick();
      waited = waited + 1;
    end
    if (exp_words.size() != 0) begin
      $display("%s: %0d expected words never came out", test_name, exp_words.size());
      failure_count = failure_count + 1;
      exp_words.delete();
      exp_is_header.delete();
      exp_ts.delete();
    end
    repeat (8) begin
      tick();  // any extra word shows up here
    end
  endtask

  task automatic apply_reset();
    @(negedge CLK);
    RESETN  = 1'b0;
    s_valid = 1'b0;
    m_ready = 1'b0;
    model_reset();
    repeat (5) @(negedge CLK);
    RESETN = 1'b1;
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    rx_words  = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic quiet_stream_test();
    begin_test("quiet_stream");
    for (int i = 0; i < 12; i++) begin
      send_word(quiet_word(), 1'b0);
      compare_flag("m_valid", 1'b0, m_valid);
    end
    send_word({8{16'hF096}}, 1'b0);  // every sample right at baseline plus threshold
    send_quiet(3, 1'b0);
    drain();
    check_word_count(0);
  endtask

  task automatic single_hit_test();
    begin_test("single_hit");
    send_quiet(4, 1'b0);
    send_word(hit_word(), 1'b0);
    send_quiet(8, 1'b0);
    drain();
    check_word_count(6);
  endtask

  task automatic spaced_hit_test();
    begin_test("spaced_hits");
    send_quiet(3, 1'b0);
    repeat (3) begin
      send_word(hit_word(), 1'b0);
      send_quiet(1, 1'b0);
    end
    send_quiet(7, 1'b0);
    drain();
    check_word_count(10);
  endtask

  task automatic two_window_test();
    begin_test("two_windows");
    send_quiet(2, 1'b0);
    send_word(hit_word(), 1'b0);
    send_quiet(10, 1'b0);
    send_word(hit_word(), 1'b0);
    send_quiet(8, 1'b0);
    drain();
    check_word_count(12);
  endtask

  task automatic random_flow_test();
    begin_test("random_flow");
    random_ready = 1'b1;
    for (int i = 0; i < 60; i++) begin
      if (random_bits(2) == 0) begin
        send_word(hit_word(), 1'b1);
      end else begin
        send_word(quiet_word(), 1'b1);
      end
    end
    send_quiet(8, 1'b1);
    drain();
    random_ready = 1'b0;
  endtask

  task automatic reset_test();
    begin_test("reset_mid_frame");
    stall_output = 1'b1;
    send_quiet(3, 1'b0);
    send_until_full();
    compare_flag("m_valid before reset", 1'b1, m_valid);
    apply_reset();
    stall_output = 1'b0;
    compare_flag("m_valid after reset", 1'b0, m_valid);
    compare_flag("s_ready after reset", 1'b1, s_ready);
    rx_words = 0;
    send_quiet(2, 1'b0);
    send_word(hit_word(), 1'b0);  // header time stamp is 2 again
    send_quiet(8, 1'b0);
    drain();
    check_word_count(6);
  endtask

  task automatic finish_run();
    $display("run complete: %0d mismatches, %0d other failures",
             mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  initial begin
    CLK            = 1'b0;
    RESETN         = 1'b0;
    s_valid        = 1'b0;
    s_data         = '0;
    m_ready        = 1'b0;
    baseline       = 12'd100;
    threshold      = 12'd50;
    lfsr_state     = 32'h7e943026;
    mismatch_count = 0;
    failure_count  = 0;
    cycle_count    = 0;
    rx_words       = 0;
    random_ready   = 1'b0;
    stall_output   = 1'b0;
    test_name      = "startup";
    win_base       = '0;
    win_thr        = '0;
    apply_reset();
    quiet_stream_test();
    single_hit_test();
    spaced_hit_test();
    two_window_test();
    random_flow_test();
    reset_test();
    finish_run();
  end

endmodule

`default_nettype wire

//--- src/daq_channel_top.sv
`timescale 1ns/1ps
`default_nettype none

module daq_channel_top #(
  parameter int CHANNEL_ID         = 0,
  parameter int POST_TRIGGER_WORDS = 3,
  parameter int FIFO_DEPTH         = 16
) (
  input  wire                            CLK,
  input  wire                            RESETN,
  input  wire                            s_valid,
  input  wire [daq_pkg::DATA_WIDTH-1:0]  s_data,
  output wire                            s_ready,
  input  wire [daq_pkg::ADC_WIDTH-1:0]   threshold,
  input  wire [daq_pkg::ADC_WIDTH-1:0]   baseline,
  output wire                            m_valid,
  output wire [daq_pkg::DATA_WIDTH-1:0]  m_data,
  input  wire                            m_ready
);

  wire                                 beat;
  wire                                 hold_load;
  wire                                 hold_done;
  wire [daq_pkg::TIME_STAMP_WIDTH-1:0] time_stamp;
  wire                                 push;
  wire [daq_pkg::DATA_WIDTH-1:0]       push_data;
  wire                                 room;

  trig_if trig ();

  acq_timer #(
    .POST_TRIGGER_WORDS(POST_TRIGGER_WORDS)
  ) u_timer (
    .CLK(CLK), .RESETN(RESETN), .beat(beat), .hold_load(hold_load),
    .time_stamp(time_stamp), .hold_done(hold_done)
  );

  trigger_fsm u_trigger (
    .CLK(CLK), .RESETN(RESETN), .s_valid(s_valid), .s_data(s_data), .room(room),
    .s_ready(s_ready), .threshold(threshold), .baseline(baseline),
    .time_stamp(time_stamp), .hold_done(hold_done), .beat(beat),
    .hold_load(hold_load), .trig(trig.fsm)
  );

  add_header_footer #(.CHANNEL_ID(CHANNEL_ID)) u_framer (
    .CLK(CLK), .RESETN(RESETN), .trig(trig.framer), .push(push), .push_data(push_data)
  );

  frame_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .CLK(CLK), .RESETN(RESETN), .push(push), .push_data(push_data), .room(room),
    .m_valid(m_valid), .m_data(m_data), .m_ready(m_ready)
  );

endmodule

`default_nettype wire

//--- src/frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module frame_fifo #(
  parameter int DEPTH = 16
) (
  input  wire                            CLK,
  input  wire                            RESETN,
  input  wire                            push,
  input  wire [daq_pkg::DATA_WIDTH-1:0]  push_data,
  output logic                           room,
  output logic                           m_valid,
  output logic [daq_pkg::DATA_WIDTH-1:0] m_data,
  input  wire                            m_ready
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  logic [daq_pkg::DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_WIDTH-1:0]           wr_ptr;
  logic [PTR_WIDTH-1:0]           rd_ptr;
  logic [CNT_WIDTH-1:0]           count;  // entries in mem, head register excluded

  logic head_free;
  logic from_mem;
  logic bypass;
  logic to_mem;

  assign head_free = !m_valid || m_ready;
  assign from_mem  = head_free && (count != '0);
  assign bypass    = head_free && (count == '0) && push;  // straight into the head
  assign to_mem    = push && !bypass;

  // three free entries cover the words still in the framing pipeline
  assign room = (count <= CNT_WIDTH'(DEPTH - 3));

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      m_valid <= 1'b0;
    end else begin
      if (to_mem) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (from_mem) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (to_mem && !from_mem) begin
        count <= count + 1'b1;
      end else if (from_mem && !to_mem) begin
        count <= count - 1'b1;
      end
      if (head_free) begin
        m_valid <= from_mem || bypass;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (to_mem) begin
      mem[wr_ptr] <= push_data;
    end
    if (from_mem) begin
      m_data <= mem[rd_ptr];  // oldest word first, bypass only when mem is empty
    end else if (bypass) begin
      m_data <= push_data;
    end
  end

endmodule

`default_nettype wire

//--- src/add_header_footer.sv
`timescale 1ns/1ps
`default_nettype none

module add_header_footer #(
  parameter int CHANNEL_ID = 0
) (
  input  wire                            CLK,
  input  wire                            RESETN,
  trig_if.framer                         trig,
  output logic                           push,
  output logic [daq_pkg::DATA_WIDTH-1:0] push_data
);

  localparam int SIDE_WIDTH = 2 * daq_pkg::ADC_WIDTH;
  localparam logic [daq_pkg::ID_WIDTH-1:0] CHANNEL_CODE = daq_pkg::ID_WIDTH'(CHANNEL_ID);

  logic [daq_pkg::DATA_WIDTH-1:0] data_d1;
  logic [daq_pkg::DATA_WIDTH-1:0] data_d2;
  logic                           flag_d1;
  logic                           flag_d2;
  logic                           flag_d3;
  logic [SIDE_WIDTH-1:0]          side_d1;  // baseline over threshold
  logic [SIDE_WIDTH-1:0]          side_d2;

  logic [daq_pkg::DATA_WIDTH-1:0] header;
  logic [daq_pkg::DATA_WIDTH-1:0] footer;
  logic                           rising;
  logic                           falling;

  ////////////////////////////////////////////////////////////////////////////
  // frame words
  ////////////////////////////////////////////////////////////////////////////

  // the time stamp in the interface still belongs to the window that opens
  assign header = {{daq_pkg::HALF_WIDTH{1'b1}},
                   daq_pkg::FILL_NIBBLE, CHANNEL_CODE,
                   daq_pkg::FILL_NIBBLE, trig.time_stamp,
                   {daq_pkg::HEADER_PAD{1'b0}}, daq_pkg::HEADER_ID};

  assign footer = {{daq_pkg::HALF_WIDTH{1'b1}},
                   daq_pkg::FILL_NIBBLE, side_d2[SIDE_WIDTH-1 -: daq_pkg::ADC_WIDTH],
                   daq_pkg::FILL_NIBBLE, side_d2[daq_pkg::ADC_WIDTH-1:0],
                   {daq_pkg::FOOTER_PAD{1'b0}}, daq_pkg::FOOTER_ID};

  // data_d2 is the word being emitted, flag_d1 the one after it
  assign rising  = !flag_d2 && flag_d1;
  assign falling = flag_d3 && !flag_d2;

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      flag_d1 <= 1'b0;
      flag_d2 <= 1'b0;
      flag_d3 <= 1'b0;
      push    <= 1'b0;
    end else begin
      push <= trig.beat && (flag_d1 || flag_d2 || flag_d3);
      if (trig.beat) begin
        flag_d1 <= trig.triggered;
        flag_d2 <= flag_d1;
        flag_d3 <= flag_d2;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (trig.beat) begin
      data_d1 <= trig.data;
      data_d2 <= data_d1;
      side_d1 <= {trig.baseline, trig.threshold};
      side_d2 <= side_d1;
      // a single idle word between two windows closes the old frame first
      if (falling) begin
        push_data <= footer;
      end else if (rising) begin
        push_data <= header;
      end else begin
        push_data <= data_d2;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/trigger_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_fsm (
  input  wire                                  CLK,
  input  wire                                  RESETN,
  input  wire                                  s_valid,
  input  wire [daq_pkg::DATA_WIDTH-1:0]        s_data,
  input  wire                                  room,
  output logic                                 s_ready,
  input  wire [daq_pkg::ADC_WIDTH-1:0]         threshold,
  input  wire [daq_pkg::ADC_WIDTH-1:0]         baseline,
  input  wire [daq_pkg::TIME_STAMP_WIDTH-1:0]  time_stamp,
  input  wire                                  hold_done,
  output logic                                 beat,
  output logic                                 hold_load,
  trig_if.fsm                                  trig
);

  daq_pkg::trig_state_e state;
  daq_pkg::trig_state_e state_next;

  logic [daq_pkg::ADC_WIDTH:0] level;  // one bit wider so the sum cannot wrap
  logic                        hit;
  logic                        triggered_next;

  assign s_ready = room;
  assign beat    = s_valid && room;
  assign level   = {1'b0, baseline} + {1'b0, threshold};

  always_comb begin
    hit = 1'b0;
    for (int i = 0; i < daq_pkg::SAMPLES_PER_WORD; i++) begin
      if ({1'b0, s_data[i*daq_pkg::SAMPLE_WIDTH +: daq_pkg::ADC_WIDTH]} > level) begin
        hit = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // window state machine, steps on accepted beats only
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next     = state;
    triggered_next = 1'b0;
    hold_load      = 1'b0;
    if (beat) begin
      if (hit) begin
        state_next     = daq_pkg::ST_ACTIVE;
        triggered_next = 1'b1;
        hold_load      = 1'b1;  // every hit restarts the post-trigger count
      end else if (state != daq_pkg::ST_IDLE) begin
        if (hold_done) begin
          state_next = daq_pkg::ST_IDLE;  // first untriggered beat
        end else begin
          state_next     = daq_pkg::ST_HOLD;
          triggered_next = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state          <= daq_pkg::ST_IDLE;
      trig.beat      <= 1'b0;
      trig.triggered <= 1'b0;
    end else begin
      state     <= state_next;
      trig.beat <= beat;
      if (beat) begin
        trig.triggered <= triggered_next;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (beat) begin
      trig.data <= s_data;
    end
    // capture only when a new window opens
    if (beat && hit && state == daq_pkg::ST_IDLE) begin
      trig.time_stamp <= time_stamp;
      trig.threshold  <= threshold;
      trig.baseline   <= baseline;
    end
  end

endmodule

`default_nettype wire

//--- src/acq_timer.sv
`timescale 1ns/1ps
`default_nettype none

module acq_timer #(
  parameter int POST_TRIGGER_WORDS = 3
) (
  input  wire                                  CLK,
  input  wire                                  RESETN,
  input  wire                                  beat,
  input  wire                                  hold_load,
  output logic [daq_pkg::TIME_STAMP_WIDTH-1:0] time_stamp,
  output logic                                 hold_done
);

  localparam int HOLD_WIDTH =
    (POST_TRIGGER_WORDS > 0) ? $clog2(POST_TRIGGER_WORDS + 1) : 1;

  logic [HOLD_WIDTH-1:0] hold_count;

  // time stamp is the index of the beat being accepted right now
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      time_stamp <= '0;
    end else if (beat) begin
      time_stamp <= time_stamp + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      hold_count <= '0;
    end else if (hold_load) begin
      hold_count <= HOLD_WIDTH'(POST_TRIGGER_WORDS);
    end else if (beat && hold_count != '0) begin
      hold_count <= hold_count - 1'b1;  // only beats count down, idle cycles do not
    end
  end

  assign hold_done = (hold_count == '0);

endmodule

`default_nettype wire

//--- src/trig_if.sv
`timescale 1ns/1ps
`default_nettype none

// one framed beat, registered in the trigger FSM

interface trig_if;

  logic                                  beat;       // word accepted last cycle
  logic [daq_pkg::DATA_WIDTH-1:0]        data;
  logic                                  triggered;  // word lies inside a window
  logic [daq_pkg::TIME_STAMP_WIDTH-1:0]  time_stamp;
  logic [daq_pkg::ADC_WIDTH-1:0]         threshold;
  logic [daq_pkg::ADC_WIDTH-1:0]         baseline;

  // the last three hold what was in force at the first hit of a window

  modport fsm (
    output beat, data, triggered, time_stamp, threshold, baseline
  );

  modport framer (
    input beat, data, triggered, time_stamp, threshold, baseline
  );

endinterface

`default_nettype wire

//--- src/daq_pkg.sv
`default_nettype none

package daq_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // stream geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int DATA_WIDTH       = 128;
  localparam int SAMPLE_WIDTH     = 16;
  localparam int SAMPLES_PER_WORD = 8;
  localparam int ADC_WIDTH        = 12;  // upper 4 bits of every slot are ignored
  localparam int TIME_STAMP_WIDTH = 44;

  ////////////////////////////////////////////////////////////////////////////
  // header and footer fields
  ////////////////////////////////////////////////////////////////////////////

  localparam int HALF_WIDTH = 64;
  localparam int ID_WIDTH   = 4;

  // each framed field is preceded by a nibble of ones
  localparam logic [ID_WIDTH-1:0] FILL_NIBBLE = 4'b1111;

  localparam logic [ID_WIDTH-1:0] HEADER_ID = 4'b1100;
  localparam logic [ID_WIDTH-1:0] FOOTER_ID = 4'b0011;

  localparam int HEADER_PAD = HALF_WIDTH - 4 * ID_WIDTH - TIME_STAMP_WIDTH;
  localparam int FOOTER_PAD = HALF_WIDTH - 3 * ID_WIDTH - 2 * ADC_WIDTH;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACTIVE,  // the last accepted beat held a hit
    ST_HOLD     // counting down the post-trigger words
  } trig_state_e;

endpackage

`default_nettype wire
